/* bench/tb_mem_stage.sv */
// testbench for the rv32i memory stage, table driven against a byte-lane memory model
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;

    typedef struct packed {
        logic [31:0]           alu;
        logic [31:0]           rs2;
        logic [31:0]           pc;
        logic [31:0]           uimm;
        logic                  br;
        rv32_mem_pkg::cw_mem_t cm;
        rv32_mem_pkg::cw_wb_t  cw;
        logic [31:0]           exp_data;
        logic                  exp_we;
        logic                  exp_trap;
    } item_t;

    logic                          clk, rst, ex_valid, br_en, ex_ready;
    logic [31:0]                   alu_out, rs2, pc, u_imm, alu_fwd;
    rv32_mem_pkg::cw_mem_t         cw_mem;
    rv32_mem_pkg::cw_wb_t          cw_wb;
    logic                          bus_cyc, bus_stb, bus_we, bus_ack;
    logic [3:0]                    bus_sel;
    logic [31:0]                   bus_adr, bus_wdat, bus_rdat;
    logic [1:0]                    ram_wait;
    logic                          wb_valid, wb_we, wb_trap;
    rv32_mem_pkg::reg_idx_t        wb_rd;
    logic [31:0]                   wb_data, wb_pc;

    item_t       tab [0:63];
    logic [31:0] ref_mem [0:255];   // expected RAM contents
    int          n_items, exp_acc, ack_cnt, done_cnt, wb_idx, limit;
    int          cycles = 0;
    int          exp_q[$];          // accepted items, oldest first
    logic [31:0] rng;

    mem_stage_top dut (
        .clk(clk), .rst(rst), .ex_valid_i(ex_valid), .alu_out_i(alu_out), .rs2_i(rs2),
        .pc_i(pc), .u_imm_i(u_imm), .br_en_i(br_en), .cw_mem_i(cw_mem), .cw_wb_i(cw_wb),
        .ex_ready_o(ex_ready), .alu_fwd_o(alu_fwd), .cyc_o(bus_cyc), .stb_o(bus_stb),
        .we_o(bus_we), .sel_o(bus_sel), .adr_o(bus_adr), .dat_o(bus_wdat),
        .dat_i(bus_rdat), .ack_i(bus_ack), .wb_valid_o(wb_valid), .wb_we_o(wb_we),
        .wb_rd_o(wb_rd), .wb_data_o(wb_data), .wb_pc_o(wb_pc), .wb_trap_o(wb_trap)
    );

    wb_ram_model ram (
        .clk(clk), .rst(rst), .cyc_i(bus_cyc), .stb_i(bus_stb), .we_i(bus_we),
        .sel_i(bus_sel), .adr_i(bus_adr), .dat_i(bus_wdat), .wait_i(ram_wait),
        .dat_o(bus_rdat), .ack_o(bus_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);   // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [rv32_mem_pkg::xlen-1:0] exp,
                              input logic [rv32_mem_pkg::xlen-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input rv32_mem_pkg::reg_idx_t exp,
                             input rv32_mem_pkg::reg_idx_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error at %0t: %s expected %b, got %b", $time, name, exp, act));
        end
    endtask

    // appends one entry and works out its writeback from the RV32I load/store rules
    task automatic add_item(input item_t src);
        item_t       t;
        int          size;
        logic        trap;
        logic [1:0]  off;
        logic [7:0]  idx;
        logic [2:0]  f3;
        logic [31:0] word, val;
        t    = src;
        size = 0;
        trap = 1'b0;
        val  = '0;
        t.pc    = 32'h4000_0000 + 32'(4 * n_items);
        t.cw.rd = 5'(n_items % 31 + 1);
        off  = t.alu[1:0];
        idx  = t.alu[9:2];
        f3   = t.cm.mem_read ? 3'(t.cm.load_funct3) : 3'(t.cm.store_funct3);
        if (t.cm.mem_read || t.cm.mem_write) begin
            case (f3)
                3'b000:  size = 1;
                3'b001:  size = 2;
                3'b010:  size = 4;
                3'b100:  size = t.cm.mem_read ? 1 : 0;   // unsigned forms are loads only
                3'b101:  size = t.cm.mem_read ? 2 : 0;
                default: size = 0;
            endcase
            if (size == 0) begin
                trap = 1'b1;
            end else begin
                trap = (int'(off) % size) != 0;
            end
            if (!trap) begin
                exp_acc++;
                word = ref_mem[idx];
                for (int b = 0; b < size; b++) begin
                    if (t.cm.mem_write) begin
                        ref_mem[idx][8*(int'(off)+b) +: 8] = t.rs2[8*b +: 8];
                    end else begin
                        val[8*b +: 8] = word[8*(int'(off)+b) +: 8];
                    end
                end
                if (t.cm.mem_read && !f3[2] && size < 4 && val[8*size-1]) begin
                    for (int b = size; b < 4; b++) begin
                        val[8*b +: 8] = 8'hff;   // sign fill
                    end
                end
            end
        end
        case (t.cw.regfilemux_sel)
            rv32_mem_pkg::rf_br_en:    t.exp_data = {31'd0, t.br};
            rv32_mem_pkg::rf_u_imm:    t.exp_data = t.uimm;
            rv32_mem_pkg::rf_lw:       t.exp_data = val;
            rv32_mem_pkg::rf_pc_plus4: t.exp_data = t.pc + 32'd4;
            default:                   t.exp_data = t.alu;
        endcase
        t.exp_we       = t.cw.reg_we & ~trap;
        t.exp_trap     = trap;
        tab[n_items]   = t;
        n_items++;
    endtask

    task automatic add_alu(input rv32_mem_pkg::regfilemux_t sel, input logic [31:0] alu,
                           input logic br);
        item_t e;
        e      = '0;
        e.alu  = alu;
        e.rs2  = ~alu;
        e.uimm = {alu[19:0] ^ 20'h5a5a5, 12'h000};
        e.br   = br;
        e.cm   = rv32_mem_pkg::cw_mem_reset;
        e.cw.regfilemux_sel = sel;
        e.cw.reg_we         = 1'b1;
        add_item(e);
    endtask

    task automatic add_mem(input logic wr, input logic [2:0] f3, input logic [31:0] addr,
                           input logic [31:0] data);
        item_t e;
        e      = '0;
        e.alu  = addr;
        e.rs2  = data;
        e.uimm = 32'h0001_f000;
        e.cm.mem_read     = ~wr;
        e.cm.mem_write    = wr;
        e.cm.load_funct3  = rv32_mem_pkg::load_funct3_t'(f3);
        e.cm.store_funct3 = rv32_mem_pkg::store_funct3_t'(f3);
        if (wr) begin
            e.cw.regfilemux_sel = rv32_mem_pkg::rf_alu_out;
        end else begin
            e.cw.regfilemux_sel = rv32_mem_pkg::rf_lw;
        end
        e.cw.reg_we = ~wr;
        add_item(e);
    endtask

    task automatic build_table();
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = {~8'(i), 8'(i) ^ 8'h3c, 8'(i), 8'(i) + 8'h5b};
        end
        add_alu(rv32_mem_pkg::rf_alu_out, 32'h1234_5678, 1'b0);
        add_alu(rv32_mem_pkg::rf_br_en, 32'hffff_fff0, 1'b1);
        add_alu(rv32_mem_pkg::rf_br_en, 32'h0000_0001, 1'b0);
        add_alu(rv32_mem_pkg::rf_u_imm, 32'h0bad_f00d, 1'b0);
        add_alu(rv32_mem_pkg::rf_pc_plus4, 32'h7777_0000, 1'b1);
        add_mem(1'b1, rv32_mem_pkg::sw, 32'h100, 32'h8765_4321);
        for (int k = 0; k < 4; k++) begin
            add_mem(1'b1, rv32_mem_pkg::sb, 32'h104 + 32'(k), 32'hdead_be70 + 32'(9 * k));
        end
        add_mem(1'b1, rv32_mem_pkg::sh, 32'h108, 32'hcafe_8001);
        add_mem(1'b1, rv32_mem_pkg::sh, 32'h10a, 32'h1234_7ffe);
        add_mem(1'b1, rv32_mem_pkg::sb, 32'h101, 32'h0000_00a5);
        add_mem(1'b1, rv32_mem_pkg::sh, 32'h102, 32'h0000_f00f);
        add_mem(1'b1, rv32_mem_pkg::sw, 32'h10c, 32'h0123_4567);
        add_alu(rv32_mem_pkg::rf_alu_out, 32'h0000_0104, 1'b0);
        for (int k = 0; k < 4; k++) begin
            add_mem(1'b0, rv32_mem_pkg::lb, 32'h104 + 32'(k), '0);
            add_mem(1'b0, rv32_mem_pkg::lbu, 32'h104 + 32'(k), '0);
            add_mem(1'b0, rv32_mem_pkg::lb, 32'h100 + 32'(k), '0);
        end
        for (int k = 0; k < 4; k += 2) begin
            add_mem(1'b0, rv32_mem_pkg::lh, 32'h108 + 32'(k), '0);
            add_mem(1'b0, rv32_mem_pkg::lhu, 32'h108 + 32'(k), '0);
            add_mem(1'b0, rv32_mem_pkg::lh, 32'h100 + 32'(k), '0);
            add_mem(1'b0, rv32_mem_pkg::lhu, 32'h100 + 32'(k), '0);
        end
        for (int k = 0; k < 16; k += 4) begin
            add_mem(1'b0, rv32_mem_pkg::lw, 32'h100 + 32'(k), '0);
        end
        // untouched words still hold the fill pattern
        add_mem(1'b0, rv32_mem_pkg::lw, 32'h3fc, '0);
        add_mem(1'b0, rv32_mem_pkg::lh, 32'h2e2, '0);
        add_mem(1'b0, rv32_mem_pkg::lbu, 32'h1ff, '0);
        add_mem(1'b0, rv32_mem_pkg::lhu, 32'h0f6, '0);
        // misaligned and illegal codes, none of these may reach the bus
        add_mem(1'b0, rv32_mem_pkg::lw, 32'h102, '0);
        add_mem(1'b0, rv32_mem_pkg::lh, 32'h105, '0);
        add_mem(1'b0, rv32_mem_pkg::lhu, 32'h107, '0);
        add_mem(1'b1, rv32_mem_pkg::sw, 32'h10d, 32'hffff_ffff);
        add_mem(1'b1, rv32_mem_pkg::sh, 32'h103, 32'hffff_ffff);
        add_mem(1'b0, 3'b011, 32'h100, '0);
        add_mem(1'b0, 3'b110, 32'h104, '0);
        add_mem(1'b0, 3'b111, 32'h108, '0);
        add_mem(1'b1, 3'b100, 32'h10c, 32'hffff_ffff);
        add_mem(1'b1, 3'b011, 32'h100, 32'hffff_ffff);
        add_alu(rv32_mem_pkg::rf_u_imm, 32'h000f_ffff, 1'b1);
        for (int k = 0; k < 16; k += 4) begin
            add_mem(1'b0, rv32_mem_pkg::lw, 32'h100 + 32'(k), '0);
        end
    endtask

    task automatic send_item(input int i);
        logic [31:0] r;
        int          gap;
        r        = next_rand();
        ram_wait = r[1:0];
        gap      = r[4] ? int'(r[3:2]) : 0;   // back-to-back about half the time
        ex_valid = 1'b0;
        repeat (gap) @(negedge clk);
        alu_out  = tab[i].alu;
        rs2      = tab[i].rs2;
        pc       = tab[i].pc;
        u_imm    = tab[i].uimm;
        br_en    = tab[i].br;
        cw_mem   = tab[i].cm;
        cw_wb    = tab[i].cw;
        ex_valid = 1'b1;
        while (!ex_ready) @(negedge clk);
        @(negedge clk);   // taken at the rising edge just passed
        exp_q.push_back(i);
        check_word("alu_fwd_o", tab[i].alu, alu_fwd);
        ex_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst && bus_ack) ack_cnt++;
        if (!rst && wb_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("writeback pulse with no item outstanding");
            end else begin
                wb_idx = exp_q.pop_front();
                if (!tab[wb_idx].exp_trap) check_word("wb_data_o", tab[wb_idx].exp_data, wb_data);
                check_word("wb_pc_o", tab[wb_idx].pc, wb_pc);
                check_reg("wb_rd_o", tab[wb_idx].cw.rd, wb_rd);
                check_flag("wb_we_o", tab[wb_idx].exp_we, wb_we);
                check_flag("wb_trap_o", tab[wb_idx].exp_trap, wb_trap);
                done_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d items written back",
                                cycles, done_cnt, n_items));
        end
    end

    initial begin
        rst      = 1'b1;
        ex_valid = 1'b0;
        alu_out  = '0;
        rs2      = '0;
        pc       = '0;
        u_imm    = '0;
        br_en    = 1'b0;
        cw_mem   = rv32_mem_pkg::cw_mem_reset;
        cw_wb    = rv32_mem_pkg::cw_wb_reset;
        ram_wait = 2'd0;
        rng      = 32'd67;
        n_items  = 0;
        exp_acc  = 0;
        ack_cnt  = 0;
        done_cnt = 0;
        build_table();
        limit = n_items * 10 + 50;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("cyc_o", 1'b0, bus_cyc);
        check_flag("wb_valid_o", 1'b0, wb_valid);
        check_flag("ex_ready_o", 1'b1, ex_ready);
        for (int i = 0; i < n_items; i++) begin
            send_item(i);
        end
        while (done_cnt < n_items) @(negedge clk);
        if (ack_cnt != exp_acc) begin
            abort_run($sformatf("** Error at %0t: bus accesses expected %0d, got %0d",
                                $time, exp_acc, ack_cnt));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* bench/wb_ram_model.sv */
// Wishbone classic RAM model, 256 words with byte selects and ack wait states
`timescale 1ns/100ps
`default_nettype none

module wb_ram_model (
    input  wire         clk,
    input  wire         rst,
    input  wire         cyc_i,
    input  wire         stb_i,
    input  wire         we_i,
    input  wire  [3:0]  sel_i,
    input  wire  [31:0] adr_i,
    input  wire  [31:0] dat_i,
    input  wire  [1:0]  wait_i,   // extra cycles before the ack
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0] mem [0:255];
    logic [7:0]  idx;
    logic [1:0]  waited;
    logic        fire;   // access happens at this edge

    // every byte depends on the whole word index
    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {~a, a ^ 8'h3c, a, a + 8'h5b};
    endfunction

    assign idx  = adr_i[9:2];
    assign fire = cyc_i & stb_i & ~ack_o & (waited >= wait_i);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_o  <= 1'b0;
            waited <= 2'd0;
        end else begin
            ack_o <= fire;   // single cycle ack
            if (fire) begin
                waited <= 2'd0;
            end else if (cyc_i && stb_i && !ack_o) begin
                waited <= waited + 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(8'(i));
            end
        end else if (fire) begin
            dat_o <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (we_i && sel_i[b]) begin
                    mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* include/rv32_mem_pkg.sv */
// rv32i memory stage shared types, control words and reset constants
`default_nettype none

package rv32_mem_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h4000_0000;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // writeback source, rf_ prefix keeps rf_lw apart from the load code lw
    typedef enum logic [2:0] {
        rf_alu_out  = 3'b000,
        rf_br_en    = 3'b001,
        rf_u_imm    = 3'b010,
        rf_lw       = 3'b011,
        rf_pc_plus4 = 3'b100
    } regfilemux_t;

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic          mem_read;
        logic          mem_write;
        load_funct3_t  load_funct3;
        store_funct3_t store_funct3;
    } cw_mem_t;

    typedef struct packed {
        regfilemux_t regfilemux_sel;
        logic        reg_we;
        reg_idx_t    rd;
    } cw_wb_t;

    localparam cw_mem_t cw_mem_reset = '{mem_read: 1'b0, mem_write: 1'b0,
                                         load_funct3: lw, store_funct3: sw};
    localparam cw_wb_t cw_wb_reset = '{regfilemux_sel: rf_alu_out, reg_we: 1'b0, rd: 5'd0};

endpackage

`default_nettype wire

/* rtl/exe_mem_reg.sv */
// EX/MEM register with address, byte mask, store lane alignment and trap detection
`timescale 1ns/100ps
`default_nettype none

module exe_mem_reg (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                exe_mem_ld_i,
    input  wire                                mem_wb_ld_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       alu_out_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       rs2_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       pc_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       u_imm_i,
    input  wire                                br_en_i,
    input  wire rv32_mem_pkg::cw_mem_t         cw_mem_i,
    input  wire rv32_mem_pkg::cw_wb_t          cw_wb_i,
    output logic                               exe_mem_valid_o,
    output logic                               mem_req_o,
    output logic                               mem_we_o,
    output logic [rv32_mem_pkg::xlen-1:0]      mem_addr_o,
    output logic [3:0]                         mem_sel_o,
    output logic [rv32_mem_pkg::xlen-1:0]      mem_wdata_o,
    output logic [rv32_mem_pkg::xlen-1:0]      alu_fwd_o,
    output logic [rv32_mem_pkg::xlen-1:0]      pc_o,
    output logic [rv32_mem_pkg::xlen-1:0]      u_imm_o,
    output logic                               br_en_o,
    output rv32_mem_pkg::cw_mem_t              cw_mem_o,
    output rv32_mem_pkg::cw_wb_t               cw_wb_o,
    output logic [1:0]                         byte_off_o,
    output logic                               trap_o
);

    logic [1:0] off;
    logic [3:0] sel_c;
    logic       trap_c;
    logic       req_c;
    logic       req_r;   // bus access wanted by the held item

    assign off = alu_out_i[1:0];

    always_comb begin
        sel_c  = 4'b0000;
        trap_c = 1'b0;
        if (cw_mem_i.mem_read) begin
            case (cw_mem_i.load_funct3)
                rv32_mem_pkg::lw: begin
                    sel_c  = 4'b1111;
                    trap_c = (off != 2'b00);
                end
                rv32_mem_pkg::lh, rv32_mem_pkg::lhu: begin
                    sel_c  = 4'b0011 << off;
                    trap_c = off[0];   // odd halfword address
                end
                rv32_mem_pkg::lb, rv32_mem_pkg::lbu: sel_c = 4'b0001 << off;
                default: trap_c = 1'b1;
            endcase
        end else if (cw_mem_i.mem_write) begin
            case (cw_mem_i.store_funct3)
                rv32_mem_pkg::sw: begin
                    sel_c  = 4'b1111;
                    trap_c = (off != 2'b00);
                end
                rv32_mem_pkg::sh: begin
                    sel_c  = 4'b0011 << off;
                    trap_c = off[0];
                end
                rv32_mem_pkg::sb: sel_c = 4'b0001 << off;
                default: trap_c = 1'b1;
            endcase
        end
    end

    assign req_c = (cw_mem_i.mem_read | cw_mem_i.mem_write) & ~trap_c;

    // control state
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            exe_mem_valid_o <= 1'b0;
            req_r           <= 1'b0;
            trap_o          <= 1'b0;
            mem_we_o        <= 1'b0;
            cw_mem_o        <= rv32_mem_pkg::cw_mem_reset;
            cw_wb_o         <= rv32_mem_pkg::cw_wb_reset;
            pc_o            <= rv32_mem_pkg::reset_pc;
        end else if (exe_mem_ld_i) begin
            exe_mem_valid_o <= 1'b1;
            req_r           <= req_c;
            trap_o          <= trap_c;
            mem_we_o        <= cw_mem_i.mem_write;
            cw_mem_o        <= cw_mem_i;
            cw_wb_o         <= cw_wb_i;
            pc_o            <= pc_i;
        end else if (mem_wb_ld_i) begin
            exe_mem_valid_o <= 1'b0;   // moved on, nothing new behind it
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (exe_mem_ld_i) begin
            mem_addr_o  <= {alu_out_i[rv32_mem_pkg::xlen-1:2], 2'b00};
            mem_sel_o   <= sel_c;
            mem_wdata_o <= rs2_i << {off, 3'b000};   // data into its byte lanes
            alu_fwd_o   <= alu_out_i;
            u_imm_o     <= u_imm_i;
            br_en_o     <= br_en_i;
            byte_off_o  <= off;
        end
    end

    assign mem_req_o = exe_mem_valid_o & req_r;

    a_sel_nonzero: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> (mem_sel_o != 4'b0000))
        else $error("memory request with empty byte mask");

endmodule

`default_nettype wire

/* rtl/load_extract.sv */
// load byte and halfword selection with sign or zero extension
`timescale 1ns/100ps
`default_nettype none

module load_extract (
    input  wire [rv32_mem_pkg::xlen-1:0]       rdata_i,
    input  wire [1:0]                          byte_off_i,
    input  wire rv32_mem_pkg::load_funct3_t    load_funct3_i,
    output logic [rv32_mem_pkg::xlen-1:0]      load_data_o
);

    logic [rv32_mem_pkg::xlen-1:0] shifted;

    // addressed byte or half lands in the low lanes
    assign shifted = rdata_i >> {byte_off_i, 3'b000};

    always_comb begin
        case (load_funct3_i)
            rv32_mem_pkg::lb:  load_data_o = {{24{shifted[7]}}, shifted[7:0]};
            rv32_mem_pkg::lbu: load_data_o = {24'd0, shifted[7:0]};
            rv32_mem_pkg::lh:  load_data_o = {{16{shifted[15]}}, shifted[15:0]};
            rv32_mem_pkg::lhu: load_data_o = {16'd0, shifted[15:0]};
            default:           load_data_o = rdata_i;   // lw, offset is zero
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mem_stage_top.sv */
// rv32i memory stage top, EX/MEM to MEM/WB with Wishbone data bus
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                ex_valid_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       alu_out_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       rs2_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       pc_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       u_imm_i,
    input  wire                                br_en_i,
    input  wire rv32_mem_pkg::cw_mem_t         cw_mem_i,
    input  wire rv32_mem_pkg::cw_wb_t          cw_wb_i,
    output logic                               ex_ready_o,
    output logic [rv32_mem_pkg::xlen-1:0]      alu_fwd_o,
    output logic                               cyc_o,
    output logic                               stb_o,
    output logic                               we_o,
    output logic [3:0]                         sel_o,
    output logic [rv32_mem_pkg::xlen-1:0]      adr_o,
    output logic [rv32_mem_pkg::xlen-1:0]      dat_o,
    input  wire [rv32_mem_pkg::xlen-1:0]       dat_i,
    input  wire                                ack_i,
    output logic                               wb_valid_o,
    output logic                               wb_we_o,
    output rv32_mem_pkg::reg_idx_t             wb_rd_o,
    output logic [rv32_mem_pkg::xlen-1:0]      wb_data_o,
    output logic [rv32_mem_pkg::xlen-1:0]      wb_pc_o,
    output logic                               wb_trap_o
);

    logic                          exe_mem_ld, mem_wb_ld;
    logic                          exe_mem_valid, mem_req, mem_busy;
    logic                          mem_we, br_en, trap;
    logic [3:0]                    mem_sel;
    logic [1:0]                    byte_off;
    logic [rv32_mem_pkg::xlen-1:0] mem_addr, mem_wdata, pc, u_imm;
    logic [rv32_mem_pkg::xlen-1:0] rdata, load_data;
    rv32_mem_pkg::cw_mem_t         cw_mem;
    rv32_mem_pkg::cw_wb_t          cw_wb;

    pipe_ctrl u_ctrl (
        .clk(clk), .rst(rst), .ex_valid_i(ex_valid_i),
        .exe_mem_valid_i(exe_mem_valid), .mem_busy_i(mem_busy),
        .ex_ready_o(ex_ready_o), .exe_mem_ld_o(exe_mem_ld), .mem_wb_ld_o(mem_wb_ld)
    );

    exe_mem_reg u_exe_mem (
        .clk(clk), .rst(rst), .exe_mem_ld_i(exe_mem_ld), .mem_wb_ld_i(mem_wb_ld),
        .alu_out_i(alu_out_i), .rs2_i(rs2_i), .pc_i(pc_i), .u_imm_i(u_imm_i),
        .br_en_i(br_en_i), .cw_mem_i(cw_mem_i), .cw_wb_i(cw_wb_i),
        .exe_mem_valid_o(exe_mem_valid), .mem_req_o(mem_req), .mem_we_o(mem_we),
        .mem_addr_o(mem_addr), .mem_sel_o(mem_sel), .mem_wdata_o(mem_wdata),
        .alu_fwd_o(alu_fwd_o), .pc_o(pc), .u_imm_o(u_imm), .br_en_o(br_en),
        .cw_mem_o(cw_mem), .cw_wb_o(cw_wb), .byte_off_o(byte_off), .trap_o(trap)
    );

    wb_data_port u_bus (
        .clk(clk), .rst(rst), .mem_req_i(mem_req), .mem_we_i(mem_we),
        .mem_addr_i(mem_addr), .mem_sel_i(mem_sel), .mem_wdata_i(mem_wdata),
        .dat_i(dat_i), .ack_i(ack_i), .mem_busy_o(mem_busy), .rdata_o(rdata),
        .cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o), .sel_o(sel_o),
        .adr_o(adr_o), .dat_o(dat_o)
    );

    load_extract u_load (
        .rdata_i(rdata), .byte_off_i(byte_off),
        .load_funct3_i(cw_mem.load_funct3), .load_data_o(load_data)
    );

    mem_wb_reg u_mem_wb (
        .clk(clk), .rst(rst), .mem_wb_ld_i(mem_wb_ld), .alu_fwd_i(alu_fwd_o),
        .load_data_i(load_data), .u_imm_i(u_imm), .br_en_i(br_en), .pc_i(pc),
        .cw_wb_i(cw_wb), .trap_i(trap),
        .wb_valid_o(wb_valid_o), .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o), .wb_pc_o(wb_pc_o), .wb_trap_o(wb_trap_o)
    );

endmodule

`default_nettype wire

/* rtl/mem_wb_reg.sv */
// MEM/WB register with writeback value selection
`timescale 1ns/100ps
`default_nettype none

module mem_wb_reg (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                mem_wb_ld_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       alu_fwd_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       load_data_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       u_imm_i,
    input  wire                                br_en_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       pc_i,
    input  wire rv32_mem_pkg::cw_wb_t          cw_wb_i,
    input  wire                                trap_i,
    output logic                               wb_valid_o,
    output logic                               wb_we_o,
    output rv32_mem_pkg::reg_idx_t             wb_rd_o,
    output logic [rv32_mem_pkg::xlen-1:0]      wb_data_o,
    output logic [rv32_mem_pkg::xlen-1:0]      wb_pc_o,
    output logic                               wb_trap_o
);

    logic [rv32_mem_pkg::xlen-1:0] wb_sel;

    always_comb begin
        case (cw_wb_i.regfilemux_sel)
            rv32_mem_pkg::rf_br_en:    wb_sel = {{(rv32_mem_pkg::xlen-1){1'b0}}, br_en_i};
            rv32_mem_pkg::rf_u_imm:    wb_sel = u_imm_i;
            rv32_mem_pkg::rf_lw:       wb_sel = load_data_i;
            rv32_mem_pkg::rf_pc_plus4: wb_sel = pc_i + 32'd4;
            default:                   wb_sel = alu_fwd_i;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            wb_trap_o  <= 1'b0;
            wb_pc_o    <= rv32_mem_pkg::reset_pc;
        end else begin
            wb_valid_o <= mem_wb_ld_i;   // one pulse per item
            wb_we_o    <= mem_wb_ld_i & cw_wb_i.reg_we & ~trap_i;
            wb_trap_o  <= mem_wb_ld_i & trap_i;
            if (mem_wb_ld_i) begin
                wb_pc_o <= pc_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_ld_i) begin
            wb_data_o <= wb_sel;
            wb_rd_o   <= cw_wb_i.rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/pipe_ctrl.sv */
// memory stage control, register load enables and upstream ready
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl (
    input  wire  clk,
    input  wire  rst,
    input  wire  ex_valid_i,
    input  wire  exe_mem_valid_i,
    input  wire  mem_busy_i,
    output logic ex_ready_o,
    output logic exe_mem_ld_o,
    output logic mem_wb_ld_o
);

    logic       advance;     // EX/MEM item moves into MEM/WB
    logic       wb_pend;     // mirrors the MEM/WB valid pulse
    logic [1:0] in_flight;

    assign advance = exe_mem_valid_i & ~mem_busy_i;

    // no path from ex_valid_i, only stage state
    assign ex_ready_o   = ~exe_mem_valid_i | advance;
    assign exe_mem_ld_o = ex_valid_i & ex_ready_o;
    assign mem_wb_ld_o  = advance;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_pend   <= 1'b0;
            in_flight <= 2'd0;
        end else begin
            wb_pend   <= advance;
            // entry into EX/MEM counts up, leaving MEM/WB counts down
            in_flight <= in_flight + {1'b0, exe_mem_ld_o} - {1'b0, wb_pend};
        end
    end

    a_max_two: assert property (@(posedge clk) disable iff (rst)
        in_flight <= 2'd2)
        else $error("more than two items in the memory stage");

endmodule

`default_nettype wire

/* rtl/wb_data_port.sv */
// Wishbone classic master, one data access per memory operation
`timescale 1ns/100ps
`default_nettype none

module wb_data_port (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                mem_req_i,
    input  wire                                mem_we_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       mem_addr_i,
    input  wire [3:0]                          mem_sel_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       mem_wdata_i,
    input  wire [rv32_mem_pkg::xlen-1:0]       dat_i,
    input  wire                                ack_i,
    output logic                               mem_busy_o,
    output logic [rv32_mem_pkg::xlen-1:0]      rdata_o,
    output logic                               cyc_o,
    output logic                               stb_o,
    output logic                               we_o,
    output logic [3:0]                         sel_o,
    output logic [rv32_mem_pkg::xlen-1:0]      adr_o,
    output logic [rv32_mem_pkg::xlen-1:0]      dat_o
);

    logic done;   // ack seen for the item still held in EX/MEM

    // done is high only in the cycle after the ack, which is the cycle the
    // stage advances, so it is back to zero when EX/MEM takes the next item
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= ack_i & stb_o;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_i && stb_o) begin
            rdata_o <= dat_i;   // read data for load_extract
        end
    end

    assign stb_o      = mem_req_i & ~done;
    assign cyc_o      = stb_o;
    assign mem_busy_o = mem_req_i & ~done;   // held until the ack has landed

    // EX/MEM holds these steady until the ack
    assign we_o  = mem_we_i;
    assign sel_o = mem_sel_i;
    assign adr_o = mem_addr_i;
    assign dat_o = mem_wdata_i;

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> stb_o)
        else $error("ack without an open bus cycle");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_mem_stage -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage \
    || exit 1

/* vlog.f */
include/rv32_mem_pkg.sv
rtl/exe_mem_reg.sv
rtl/wb_data_port.sv
rtl/load_extract.sv
rtl/mem_wb_reg.sv
rtl/pipe_ctrl.sv
rtl/mem_stage_top.sv
bench/wb_ram_model.sv
bench/tb_mem_stage.sv
